/* wb_top.f */
rtl/wb_pkg.sv
rtl/wb_ex_pipe_reg.sv
rtl/wb_stage.sv
rtl/wb_regfile.sv
rtl/wb_trap_capture.sv
rtl/wb_top.sv
dv/wb_sva.sv
dv/wb_tb.sv

/* dv/wb_tests.txt */
# kind(0 ALU,1 LOAD,2 XIF) rd pc data delay(ff random) mpu align wpt exc kill halt clr
# All columns hex; clr pulses trap_clr_i before the instruction is issued
0 01 0100 11111111 00 0 0 0 0 0 00 0
0 02 0104 22222222 00 0 0 0 0 0 00 0
0 00 0108 deadbeef 00 0 0 0 0 0 00 0
0 1f 010c a5a5a5a5 00 0 0 0 0 0 00 0
1 03 0110 cafef00d ff 0 0 0 0 0 00 0
1 04 0114 12345678 ff 0 0 0 0 0 00 0
1 05 0118 0badc0de 03 0 0 0 0 0 00 0
1 06 011c 55aa55aa ff 1 0 0 0 0 00 0
1 07 0120 66666666 02 0 1 0 0 0 00 0
1 08 0124 88888888 01 0 0 4 0 0 00 0
2 09 0128 77777777 02 0 0 0 0 0 00 0
2 0a 012c 99999999 01 0 0 0 1 0 00 0
1 0b 0130 bbbbbbbb 02 2 1 1 0 0 00 1
1 0c 0134 cccccccc 02 0 1 2 0 0 00 1
1 0d 0138 dddddddd 01 0 0 8 0 0 00 1
2 0e 013c eeeeeeee 03 0 0 0 1 0 00 1
0 0f 0140 f0f0f0f0 00 0 0 0 0 1 00 0
1 10 0144 10101010 02 0 0 0 0 1 00 0
2 11 0148 11110000 02 0 0 0 0 1 00 0
0 12 014c 12121212 00 0 0 0 0 0 05 0
1 13 0150 13131313 02 0 0 0 0 0 06 0
2 14 0154 14141414 02 0 0 0 0 0 03 0
1 15 0158 15151515 ff 0 0 0 0 0 00 0
0 01 015c 01010101 00 0 0 0 0 0 00 0
1 16 0160 16161616 01 1 0 0 0 0 04 0
1 17 0164 17171717 ff 0 0 0 0 0 00 0
2 18 0168 18181818 ff 0 0 0 0 0 00 1
1 00 016c 00c0ffee ff 0 0 0 0 0 00 0

/* dv/wb_tb.sv */
////////////////////////////////////////////////////////////
// Testbench for the write-back subsystem, stimulus and
// expected values come from the tests file
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_tb import wb_pkg::*;;

  localparam int unsigned WPT_W      = 4;
  localparam int unsigned CLK_PERIOD = 4;
  localparam int unsigned RST_CYCLES = 16;

  // One line of the tests file
  typedef struct packed {
    logic [1:0]  kind;
    logic [4:0]  rd;
    logic [15:0] pc;
    logic [31:0] data;
    logic [7:0]  delay;
    logic [1:0]  mpu;
    logic        align;
    logic [3:0]  wpt;
    logic        exc;
    logic        kill;
    logic [7:0]  halt;
    logic        clr;
  } test_t;

  logic clk;
  logic rst_n;
  logic ex_valid_i;
  ex_wb_pipe_t ex_instr_i;
  logic ex_ready_o;
  ctrl_t ctrl_i;
  lsu_resp_t lsu_resp_i;
  logic [WPT_W-1:0] lsu_wpt_i;
  logic lsu_pending_o;
  logic xif_valid_i;
  xif_result_t xif_result_i;
  logic xif_ready_o;
  logic wb_valid_o;
  rf_addr_t rf_raddr_i;
  logic [31:0] rf_rdata_o;
  logic trap_clr_i;
  logic [31:0] retire_cnt_o;
  trap_cause_e trap_cause_o;
  logic [15:0] trap_pc_o;
  logic [WPT_W-1:0] trap_wpt_o;

  test_t tests[$];
  // Reference state built from the rules of the write-back stage
  logic [31:0] model_rf [32];
  logic [31:0] exp_cnt;
  trap_cause_e exp_cause;
  logic [15:0] exp_pc;
  logic [WPT_W-1:0] exp_wpt;
  int unsigned wb_valid_events;
  int unsigned n_errors;
  integer seed;
  integer fd;
  logic tests_loaded;

  wb_top #(.WPT_W(WPT_W)) UUT (
    .clk (clk), .rst_n (rst_n),
    .ex_valid_i (ex_valid_i), .ex_instr_i (ex_instr_i), .ex_ready_o (ex_ready_o),
    .ctrl_i (ctrl_i),
    .lsu_resp_i (lsu_resp_i), .lsu_wpt_i (lsu_wpt_i), .lsu_pending_o (lsu_pending_o),
    .xif_valid_i (xif_valid_i), .xif_result_i (xif_result_i), .xif_ready_o (xif_ready_o),
    .wb_valid_o (wb_valid_o), .rf_raddr_i (rf_raddr_i), .rf_rdata_o (rf_rdata_o),
    .trap_clr_i (trap_clr_i), .retire_cnt_o (retire_cnt_o),
    .trap_cause_o (trap_cause_o), .trap_pc_o (trap_pc_o), .trap_wpt_o (trap_wpt_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Every retire strobe, aborted or not, seen on a rising edge
  always @(posedge clk) begin
    if (rst_n && wb_valid_o) wb_valid_events++;
  end

  // Watchdog sized from the number of test lines
  initial begin
    wait (tests_loaded === 1'b1);
    #((RST_CYCLES + 64 * tests.size()) * CLK_PERIOD);
    $display("Timeout: the test sequence did not complete within its cycle budget");
    $display("Errors found");
    $finish;
  end

  task automatic flag_failure(input string msg);
    n_errors++;
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  task automatic load_tests(input integer fh);
    string line;
    integer f [12];
    integer n;
    test_t t;
    while (!$feof(fh)) begin
      n = $fgets(line, fh);
      if ((n > 0) && (line.getc(0) != "#")) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                    f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
        if (n == 12) begin
          t = {f[0][1:0], f[1][4:0], f[2][15:0], f[3], f[4][7:0], f[5][1:0],
               f[6][0], f[7][3:0], f[8][0], f[9][0], f[10][7:0], f[11][0]};
          tests.push_back(t);
        end
      end
    end
    $fclose(fh);
  endtask

  // Abort cause by priority, NONE when the instruction retires cleanly
  function automatic trap_cause_e expected_cause(input test_t t);
    expected_cause = NONE;
    if (t.kind == LOAD) begin
      if (t.mpu != 2'd0) expected_cause = MPU;
      else if (t.align) expected_cause = ALIGN;
      else if (|t.wpt) expected_cause = WATCHPOINT;
    end else if ((t.kind == XIF) && t.exc) begin
      expected_cause = XIF_EXC;
    end
  endfunction

  task automatic hold_halt(input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (wb_valid_o) flag_failure("wb_valid_o high while halted");
      if (ex_ready_o) flag_failure("ex_ready_o high while halted");
    end
    ctrl_i.halt_wb = 1'b0;
  endtask

  // One-cycle LSU pulse, which may land while WB is halted
  task automatic drive_load_response(input test_t t, input int unsigned delay);
    repeat (delay) @(negedge clk);
    while (!lsu_pending_o) @(negedge clk);
    lsu_resp_i.rvalid       = 1'b1;
    lsu_resp_i.rdata        = t.data;
    lsu_resp_i.mpu_status   = mpu_status_e'(t.mpu);
    lsu_resp_i.align_status = align_status_e'(t.align);
    lsu_wpt_i               = t.wpt;
    @(negedge clk);
    lsu_resp_i = '0;
    lsu_wpt_i  = '0;
  endtask

  task automatic drive_xif_response(input test_t t, input int unsigned delay);
    repeat (delay) @(negedge clk);
    while (!xif_ready_o) @(negedge clk);
    xif_valid_i       = 1'b1;
    xif_result_i.data = t.data;
    xif_result_i.exc  = t.exc;
    @(negedge clk);
    xif_valid_i  = 1'b0;
    xif_result_i = '0;
  endtask

  task automatic run_test(input test_t t, input int idx);
    int unsigned start_events;
    int unsigned delay;
    trap_cause_e cause;
    @(negedge clk);
    if (t.clr) begin
      trap_clr_i = 1'b1;
      @(negedge clk);
      trap_clr_i = 1'b0;
      exp_cause  = NONE;
      exp_pc     = '0;
      exp_wpt    = '0;
    end
    delay = (t.delay == 8'hff) ? 1 + ({$random(seed)} % 6) : t.delay;
    if (delay == 0) delay = 1;
    while (!ex_ready_o) @(negedge clk);
    start_events = wb_valid_events;
    // Load and coprocessor records carry a decoy ALU result
    ex_instr_i.instr_valid = 1'b1;
    ex_instr_i.kind        = instr_kind_e'(t.kind);
    ex_instr_i.rf_we       = 1'b1;
    ex_instr_i.rf_waddr    = t.rd;
    ex_instr_i.rf_wdata    = (t.kind == ALU) ? t.data : ~t.data;
    ex_instr_i.pc          = t.pc;
    ex_instr_i.abort_op    = 1'b0;
    ex_valid_i             = 1'b1;
    rf_raddr_i             = t.rd;
    @(negedge clk);
    // The record now sits in WB with neither kill nor halt applied
    ex_valid_i     = 1'b0;
    if ((lsu_pending_o !== (t.kind == LOAD)) || (xif_ready_o !== (t.kind == XIF)))
      flag_failure($sformatf("test %0d lsu_pending_o %b xif_ready_o %b for kind %0d", idx,
                             lsu_pending_o, xif_ready_o, t.kind));
    ctrl_i.kill_wb = t.kill;
    ctrl_i.halt_wb = !t.kill && (t.halt != 8'd0);
    fork
      if (ctrl_i.halt_wb) hold_halt(t.halt);
      if ((t.kind == LOAD) && !t.kill) drive_load_response(t, delay);
    join
    if ((t.kind == XIF) && !t.kill) drive_xif_response(t, delay);
    if (t.kill) begin
      @(negedge clk);
      ctrl_i.kill_wb = 1'b0;
      if (wb_valid_events != start_events) flag_failure("killed instruction retired");
    end else begin
      while (wb_valid_events == start_events) @(negedge clk);
      cause = expected_cause(t);
      if (cause == NONE) begin
        exp_cnt++;
        if (t.rd != 5'd0) model_rf[t.rd] = t.data;
      end else if (exp_cause == NONE) begin
        exp_cause = cause;
        exp_pc    = t.pc;
        exp_wpt   = (t.kind == LOAD) ? t.wpt : '0;
      end
    end
    if (rf_rdata_o !== model_rf[t.rd])
      flag_failure($sformatf("test %0d x%0d read %h, expected %h", idx, t.rd,
                             rf_rdata_o, model_rf[t.rd]));
    if (retire_cnt_o !== exp_cnt)
      flag_failure($sformatf("test %0d retire count %0d, expected %0d", idx,
                             retire_cnt_o, exp_cnt));
    if ((trap_cause_o !== exp_cause) || (trap_pc_o !== exp_pc) || (trap_wpt_o !== exp_wpt))
      flag_failure($sformatf("test %0d trap %s pc %h wpt %h, expected %s pc %h wpt %h",
                             idx, trap_cause_o.name(), trap_pc_o, trap_wpt_o,
                             exp_cause.name(), exp_pc, exp_wpt));
  endtask

  initial begin
    rst_n        = 1'b0;
    ex_valid_i   = 1'b0;
    ex_instr_i   = '0;
    ctrl_i       = '0;
    lsu_resp_i   = '0;
    lsu_wpt_i    = '0;
    xif_valid_i  = 1'b0;
    xif_result_i = '0;
    rf_raddr_i   = '0;
    trap_clr_i   = 1'b0;
    seed         = 32'h19b8_a19e;
    n_errors     = 0;
    exp_cnt      = '0;
    exp_cause    = NONE;
    exp_pc       = '0;
    exp_wpt      = '0;
    tests_loaded = 1'b0;
    wb_valid_events = 0;
    for (int i = 0; i < 32; i++) model_rf[i] = '0;
    fd = $fopen("dv/wb_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the tests file dv/wb_tests.txt");
      $display("Errors found");
      $finish;
    end else begin
      load_tests(fd);
      tests_loaded = 1'b1;
      repeat (RST_CYCLES) @(negedge clk);
      if (ex_ready_o) flag_failure("ex_ready_o high during reset");
      if (wb_valid_o || lsu_pending_o || xif_ready_o)
        flag_failure("wb_valid_o, lsu_pending_o or xif_ready_o high during reset");
      if ((retire_cnt_o !== '0) || (trap_cause_o !== NONE))
        flag_failure("retire count or trap cause not cleared by reset");
      rst_n = 1'b1;
      foreach (tests[i]) run_test(tests[i], i);
      @(negedge clk);
      n_errors += UUT.u_wb_stage.u_wb_sva.fail_cnt;
      $display("Summary: %0d tests run, %0d errors", tests.size(), n_errors);
      if (n_errors == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dv/wb_sva.sv */
////////////////////////////////////////////////////////////
// Assertions on the write and retire rules of the WB stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_sva import wb_pkg::*; #(
  parameter int unsigned WPT_W = 4
) (
  input logic             clk,
  input logic             rst_n,
  input ex_wb_pipe_t      ex_wb_pipe_i,
  input ctrl_t            ctrl_i,
  input lsu_resp_t        lsu_resp_i,
  input logic [WPT_W-1:0] lsu_wpt_i,
  input logic             xif_valid_i,
  input xif_result_t      xif_result_i,
  input logic             rf_we_o,
  input logic             wb_valid_o
);

  logic        load_bad;
  logic        load_bad_q;
  logic        xif_bad;
  // Number of assertion failures so far
  int unsigned fail_cnt = 0;

  // Live response for the load in WB carrying a protection, alignment or watchpoint fault
  assign load_bad = ex_wb_pipe_i.instr_valid && (ex_wb_pipe_i.kind == LOAD) &&
                    lsu_resp_i.rvalid &&
                    ((lsu_resp_i.mpu_status != MPU_OK) ||
                     (lsu_resp_i.align_status != ALIGN_OK) || (|lsu_wpt_i));
  // Coprocessor result flagged as an exception
  assign xif_bad  = ex_wb_pipe_i.instr_valid && (ex_wb_pipe_i.kind == XIF) &&
                    xif_valid_i && xif_result_i.exc;

  // A bad response that lands during a halt still blocks the write once the load retires
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_bad_q <= 1'b0;
    end else if (wb_valid_o || ctrl_i.kill_wb) begin
      load_bad_q <= 1'b0;
    end else if (load_bad) begin
      load_bad_q <= 1'b1;
    end
  end

  // The register file is only written in a retiring cycle
  we_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
    rf_we_o |-> wb_valid_o)
    else begin
      $error("rf_we_o high without wb_valid_o");
      fail_cnt++;
    end

  // Any bad status kills the write
  bad_status_no_we: assert property (@(posedge clk) disable iff (!rst_n)
    (load_bad || load_bad_q || xif_bad) |-> !rf_we_o)
    else begin
      $error("rf_we_o high with a bad status");
      fail_cnt++;
    end

  // Halt freezes WB completely
  halt_no_valid: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_i.halt_wb |-> (!wb_valid_o && !rf_we_o))
    else begin
      $error("wb_valid_o or rf_we_o high while halted");
      fail_cnt++;
    end

endmodule

bind wb_stage wb_sva #(.WPT_W(WPT_W)) u_wb_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .ex_wb_pipe_i (ex_wb_pipe_i),
  .ctrl_i       (ctrl_i),
  .lsu_resp_i   (lsu_resp_i),
  .lsu_wpt_i    (lsu_wpt_i),
  .xif_valid_i  (xif_valid_i),
  .xif_result_i (xif_result_i),
  .rf_we_o      (rf_we_o),
  .wb_valid_o   (wb_valid_o)
);

`default_nettype wire

/* rtl/wb_top.sv */
////////////////////////////////////////////////////////////
// Write-back subsystem top with pipeline register, WB stage,
// register file and trap capture
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_top import wb_pkg::*; #(
  parameter int unsigned WPT_W = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  // Execute stage
  input  logic             ex_valid_i,
  input  ex_wb_pipe_t      ex_instr_i,
  output logic             ex_ready_o,
  // Kill and halt
  input  ctrl_t            ctrl_i,
  // Load/store unit
  input  lsu_resp_t        lsu_resp_i,
  input  logic [WPT_W-1:0] lsu_wpt_i,
  output logic             lsu_pending_o,
  // Coprocessor
  input  logic             xif_valid_i,
  input  xif_result_t      xif_result_i,
  output logic             xif_ready_o,
  // Retire strobe and register read port
  output logic             wb_valid_o,
  input  rf_addr_t         rf_raddr_i,
  output logic [31:0]      rf_rdata_o,
  // Trap capture
  input  logic             trap_clr_i,
  output logic [31:0]      retire_cnt_o,
  output trap_cause_e      trap_cause_o,
  output logic [15:0]      trap_pc_o,
  output logic [WPT_W-1:0] trap_wpt_o
);

  ex_wb_pipe_t      ex_wb_pipe;
  logic             wb_ready;
  logic             rf_we;
  rf_addr_t         rf_waddr;
  logic [31:0]      rf_wdata;
  logic             abort_op;
  trap_cause_e      abort_cause;
  logic [WPT_W-1:0] wpt_match;

  wb_ex_pipe_reg u_pipe_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid_i   (ex_valid_i),
    .ex_instr_i   (ex_instr_i),
    .wb_ready_i   (wb_ready),
    .kill_wb_i    (ctrl_i.kill_wb),
    .ex_ready_o   (ex_ready_o),
    .ex_wb_pipe_o (ex_wb_pipe)
  );

  // Load stall indication has no consumer in this subsystem
  wb_stage #(.WPT_W(WPT_W)) u_wb_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_wb_pipe_i  (ex_wb_pipe),
    .ctrl_i        (ctrl_i),
    .lsu_resp_i    (lsu_resp_i),
    .lsu_wpt_i     (lsu_wpt_i),
    .xif_valid_i   (xif_valid_i),
    .xif_result_i  (xif_result_i),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .xif_ready_o   (xif_ready_o),
    .lsu_pending_o (lsu_pending_o),
    .data_stall_o  (),
    .wb_ready_o    (wb_ready),
    .wb_valid_o    (wb_valid_o),
    .abort_op_o    (abort_op),
    .abort_cause_o (abort_cause),
    .wpt_match_o   (wpt_match)
  );

  wb_regfile u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

  wb_trap_capture #(.WPT_W(WPT_W)) u_trap_capture (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_valid_i    (wb_valid_o),
    .abort_op_i    (abort_op),
    .abort_cause_i (abort_cause),
    .pc_i          (ex_wb_pipe.pc),
    .wpt_match_i   (wpt_match),
    .trap_clr_i    (trap_clr_i),
    .retire_cnt_o  (retire_cnt_o),
    .trap_cause_o  (trap_cause_o),
    .trap_pc_o     (trap_pc_o),
    .trap_wpt_o    (trap_wpt_o)
  );

endmodule

`default_nettype wire

/* rtl/wb_trap_capture.sv */
////////////////////////////////////////////////////////////
// Retire counter and capture of the first aborted instruction
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_trap_capture import wb_pkg::*; #(
  parameter int unsigned WPT_W = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wb_valid_i,
  input  logic             abort_op_i,
  input  trap_cause_e      abort_cause_i,
  input  logic [15:0]      pc_i,
  input  logic [WPT_W-1:0] wpt_match_i,
  input  logic             trap_clr_i,
  output logic [31:0]      retire_cnt_o,
  output trap_cause_e      trap_cause_o,
  output logic [15:0]      trap_pc_o,
  output logic [WPT_W-1:0] trap_wpt_o
);

  logic retire;
  logic abort;
  logic first_abort;

  assign retire = wb_valid_i && !abort_op_i;
  assign abort  = wb_valid_i && abort_op_i;

  // A trap is already held while the cause reads anything but NONE
  assign first_abort = abort && (trap_cause_o == NONE);

  //////////////////////////////////////////////////////////
  // Retire counter

  // Aborted instructions leave WB but do not count as retired
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_cnt_o <= '0;
    end else if (retire) begin
      retire_cnt_o <= retire_cnt_o + 32'd1;
    end
  end

  //////////////////////////////////////////////////////////
  // First abort

  // Clear wins over an abort in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trap_cause_o <= NONE;
      trap_pc_o    <= '0;
      trap_wpt_o   <= '0;
    end else if (trap_clr_i) begin
      trap_cause_o <= NONE;
      trap_pc_o    <= '0;
      trap_wpt_o   <= '0;
    end else if (first_abort) begin
      trap_cause_o <= abort_cause_i;
      trap_pc_o    <= pc_i;
      // Watchpoint hits of the trapping load, zero for other causes
      trap_wpt_o   <= wpt_match_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/wb_regfile.sv */
////////////////////////////////////////////////////////////
// Register file, 32 x 32 bit with x0 tied to zero
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_regfile import wb_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        we_i,
  input  rf_addr_t    waddr_i,
  input  logic [31:0] wdata_i,
  input  rf_addr_t    raddr_i,
  output logic [31:0] rdata_o
);

  logic [31:0] regs [32];

  //////////////////////////////////////////////////////////
  // Write port

  // Entry 0 is cleared by reset and never written afterwards
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  //////////////////////////////////////////////////////////
  // Read port

  // Asynchronous read, a write shows up the cycle after it is issued
  assign rdata_o = regs[raddr_i];

endmodule

`default_nettype wire

/* rtl/wb_stage.sv */
////////////////////////////////////////////////////////////
// Write-back stage merging ALU, load and coprocessor results
// into one register file write and a retire strobe
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_stage import wb_pkg::*; #(
  parameter int unsigned WPT_W = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  ex_wb_pipe_t      ex_wb_pipe_i,
  input  ctrl_t            ctrl_i,
  input  lsu_resp_t        lsu_resp_i,
  input  logic [WPT_W-1:0] lsu_wpt_i,
  input  logic             xif_valid_i,
  input  xif_result_t      xif_result_i,
  output logic             rf_we_o,
  output rf_addr_t         rf_waddr_o,
  output logic [31:0]      rf_wdata_o,
  output logic             xif_ready_o,
  output logic             lsu_pending_o,
  output logic             data_stall_o,
  output logic             wb_ready_o,
  output logic             wb_valid_o,
  output logic             abort_op_o,
  output trap_cause_e      abort_cause_o,
  output logic [WPT_W-1:0] wpt_match_o
);

  logic             is_load;
  logic             is_xif;
  logic             instr_valid;
  logic             load_wait;
  logic             xif_waiting;
  logic             xif_exception;
  logic             load_fault;
  logic             sticky_set;
  logic             sticky_clr;
  // Sticky copies of the one-cycle LSU response
  logic             lsu_valid_q;
  logic [31:0]      lsu_rdata_q;
  mpu_status_e      lsu_mpu_q;
  align_status_e    lsu_align_q;
  logic [WPT_W-1:0] lsu_wpt_q;
  // Response as seen by this cycle, live or sticky
  logic             lsu_valid;
  logic [31:0]      lsu_rdata;
  mpu_status_e      lsu_mpu;
  align_status_e    lsu_align;
  logic [WPT_W-1:0] lsu_wpt;

  assign is_load = ex_wb_pipe_i.instr_valid && (ex_wb_pipe_i.kind == LOAD);
  assign is_xif  = ex_wb_pipe_i.instr_valid && (ex_wb_pipe_i.kind == XIF);

  // Instruction is present and allowed to make progress this cycle
  assign instr_valid = ex_wb_pipe_i.instr_valid && !ctrl_i.kill_wb && !ctrl_i.halt_wb;

  //////////////////////////////////////////////////////////
  // LSU response

  // The LSU may answer while WB is halted, so the response is kept
  // until the load retires or is killed
  assign sticky_set = is_load && lsu_resp_i.rvalid && !lsu_valid_q;
  assign sticky_clr = wb_valid_o || ctrl_i.kill_wb;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_valid_q <= 1'b0;
      lsu_mpu_q   <= MPU_OK;
      lsu_align_q <= ALIGN_OK;
      lsu_wpt_q   <= '0;
    end else if (sticky_clr) begin
      lsu_valid_q <= 1'b0;
      lsu_mpu_q   <= MPU_OK;
      lsu_align_q <= ALIGN_OK;
      lsu_wpt_q   <= '0;
    end else if (sticky_set) begin
      lsu_valid_q <= 1'b1;
      lsu_mpu_q   <= lsu_resp_i.mpu_status;
      lsu_align_q <= lsu_resp_i.align_status;
      lsu_wpt_q   <= lsu_wpt_i;
    end
  end

  // Load data is payload and is only read when lsu_valid_q is set
  always_ff @(posedge clk) begin
    if (sticky_set) begin
      lsu_rdata_q <= lsu_resp_i.rdata;
    end
  end

  // Status reads as clean while no response has arrived
  always_comb begin
    lsu_valid = lsu_valid_q || lsu_resp_i.rvalid;
    lsu_rdata = lsu_resp_i.rdata;
    lsu_mpu   = MPU_OK;
    lsu_align = ALIGN_OK;
    lsu_wpt   = '0;
    if (lsu_valid_q) begin
      lsu_rdata = lsu_rdata_q;
      lsu_mpu   = lsu_mpu_q;
      lsu_align = lsu_align_q;
      lsu_wpt   = lsu_wpt_q;
    end else if (lsu_resp_i.rvalid) begin
      lsu_mpu   = lsu_resp_i.mpu_status;
      lsu_align = lsu_resp_i.align_status;
      lsu_wpt   = lsu_wpt_i;
    end
  end

  assign load_fault = is_load &&
                      ((lsu_mpu != MPU_OK) || (lsu_align != ALIGN_OK) || (|lsu_wpt));
  assign load_wait  = is_load && !lsu_valid;

  //////////////////////////////////////////////////////////
  // Coprocessor result

  // Ready only while the instruction can retire, so a transfer always retires
  assign xif_ready_o   = is_xif && !ctrl_i.kill_wb && !ctrl_i.halt_wb;
  assign xif_waiting   = is_xif && !xif_valid_i;
  assign xif_exception = is_xif && xif_valid_i && xif_result_i.exc;

  //////////////////////////////////////////////////////////
  // Retire, write and abort

  assign wb_valid_o = instr_valid && ((!is_load && !xif_waiting) || (is_load && lsu_valid));

  // Any exception suppresses the write, the instruction still retires as aborted
  assign abort_op_o = ex_wb_pipe_i.abort_op || load_fault || xif_exception;
  assign rf_we_o    = wb_valid_o && ex_wb_pipe_i.rf_we && !abort_op_o;
  assign rf_waddr_o = ex_wb_pipe_i.rf_waddr;
  assign rf_wdata_o = is_load ? lsu_rdata :
                      is_xif  ? xif_result_i.data : ex_wb_pipe_i.rf_wdata;

  // Cause priority follows the order of the encoding
  always_comb begin
    if (ex_wb_pipe_i.abort_op) abort_cause_o = UPSTREAM;
    else if (is_load && (lsu_mpu != MPU_OK)) abort_cause_o = MPU;
    else if (is_load && (lsu_align != ALIGN_OK)) abort_cause_o = ALIGN;
    else if (is_load && (|lsu_wpt)) abort_cause_o = WATCHPOINT;
    else if (xif_exception) abort_cause_o = XIF_EXC;
    else abort_cause_o = NONE;
  end

  assign lsu_pending_o = is_load;
  assign data_stall_o  = load_wait && instr_valid;
  assign wpt_match_o   = lsu_wpt;

  // Kill always empties WB, otherwise WB frees up once its record completes
  assign wb_ready_o = ctrl_i.kill_wb || (!ctrl_i.halt_wb && !xif_waiting && !load_wait);

endmodule

`default_nettype wire

/* rtl/wb_ex_pipe_reg.sv */
////////////////////////////////////////////////////////////
// EX/WB pipeline register holding one instruction record
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_ex_pipe_reg import wb_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        ex_valid_i,
  input  ex_wb_pipe_t ex_instr_i,
  input  logic        wb_ready_i,
  input  logic        kill_wb_i,
  output logic        ex_ready_o,
  output ex_wb_pipe_t ex_wb_pipe_o
);

  // Goes high on the first edge after reset release and stays high
  logic        ready_en_q;
  logic        valid_q;
  logic        transfer;
  ex_wb_pipe_t instr_q;

  // Space is available when the slot is empty or WB hands its record on
  assign ex_ready_o = ready_en_q && (!valid_q || wb_ready_i);
  assign transfer   = ex_valid_i && ex_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_en_q <= 1'b0;
      valid_q    <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
      // A kill flushes the record in WB, a record arriving in the
      // same cycle is younger and still takes the slot
      if (transfer) begin
        valid_q <= 1'b1;
      end else if (kill_wb_i || wb_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // Record payload, qualified by valid_q
  always_ff @(posedge clk) begin
    if (transfer) begin
      instr_q <= ex_instr_i;
    end
  end

  // The slot's own flag replaces whatever valid bit came along with the record
  always_comb begin
    ex_wb_pipe_o             = instr_q;
    ex_wb_pipe_o.instr_valid = valid_q;
  end

endmodule

`default_nettype wire

/* rtl/wb_pkg.sv */
////////////////////////////////////////////////////////////
// Write-back subsystem package with the pipeline record,
// LSU and coprocessor response types and trap encodings
////////////////////////////////////////////////////////////

`default_nettype none

package wb_pkg;

  //////////////////////////////////////////////////////////
  // Encodings

  // Instruction class as decoded by the execute stage
  typedef enum logic [1:0] {
    ALU  = 2'd0,
    LOAD = 2'd1,
    XIF  = 2'd2
  } instr_kind_e;

  // Memory protection outcome reported with a load response
  typedef enum logic [1:0] {
    MPU_OK       = 2'd0,
    MPU_RE_FAULT = 2'd1,
    MPU_WR_FAULT = 2'd2
  } mpu_status_e;

  // Alignment outcome reported with a load response
  typedef enum logic {
    ALIGN_OK  = 1'b0,
    ALIGN_ERR = 1'b1
  } align_status_e;

  // Cause of an aborted instruction, listed in priority order after NONE
  typedef enum logic [2:0] {
    NONE       = 3'd0,
    UPSTREAM   = 3'd1,
    MPU        = 3'd2,
    ALIGN      = 3'd3,
    WATCHPOINT = 3'd4,
    XIF_EXC    = 3'd5
  } trap_cause_e;

  typedef logic [4:0] rf_addr_t;

  //////////////////////////////////////////////////////////
  // Records

  // One instruction as it travels from EX into WB
  typedef struct packed {
    logic        instr_valid;
    instr_kind_e kind;
    logic        rf_we;
    rf_addr_t    rf_waddr;
    logic [31:0] rf_wdata;   // ALU result
    logic [15:0] pc;         // Address tag kept for trap capture
    logic        abort_op;   // Exception raised further up the pipe
  } ex_wb_pipe_t;

  // Load response, the watchpoint vector travels beside it
  typedef struct packed {
    logic          rvalid;
    logic [31:0]   rdata;
    mpu_status_e   mpu_status;
    align_status_e align_status;
  } lsu_resp_t;

  // Coprocessor result payload
  typedef struct packed {
    logic [31:0] data;
    logic        exc;
  } xif_result_t;

  // Kill and halt requests aimed at WB
  typedef struct packed {
    logic kill_wb;
    logic halt_wb;
  } ctrl_t;

endpackage

`default_nettype wire
